/* sdram_pkg.sv */
package sdram_pkg;

  // all timing in clk cycles
  localparam int unsigned T_POWERUP      = 20000; // stable-power wait
  localparam int unsigned PWR_W          = 15;    // width of the power-up count
  localparam int unsigned T_RP           = 4;     // precharge period
  localparam int unsigned T_RC           = 6;     // auto-refresh period
  localparam int unsigned T_MRD          = 6;     // mode load to next cmd
  localparam int unsigned T_RCD          = 2;     // activate to column cmd
  localparam int unsigned CAS_LAT        = 3;
  localparam int unsigned T_WR           = 2;     // write recovery
  localparam int unsigned INIT_REFRESHES = 8;

  // full-page bursts need 1..256, so 9 bits
  localparam int unsigned BURST_W = 9;
  // delay counter must reach CAS_LAT + 256
  localparam int unsigned DLY_W   = BURST_W + 1;

  // mode register value for burst r/w, CL3, sequential, full page
  localparam logic [11:0] MODE_WORD = 12'h037;

  typedef struct packed {
    logic cke;
    logic cs_n;
    logic ras_n;
    logic cas_n;
    logic we_n;
  } sdram_cmd_t;

  typedef struct packed {
    sdram_cmd_t  cmd;
    logic [1:0]  ba;
    logic [11:0] addr;
  } sdram_bus_t;

  typedef struct packed {
    logic [1:0]         bank;
    logic [11:0]        row;
    logic [7:0]         col;   // start column, wraps at 256
    logic [BURST_W-1:0] burst; // words in the transfer
  } host_req_t;

  typedef logic [15:0] sdram_word_t;

  // what the command generator can put on the pins
  typedef enum logic [3:0] {
    op_nop,
    op_precharge_all,
    op_refresh,
    op_load_mode,
    op_activate,
    op_read,
    op_write,
    op_burst_stop,
    op_precharge_bank
  } sdram_op_e;

  // pin encodings {cke, cs_n, ras_n, cas_n, we_n}
  localparam sdram_cmd_t CMD_INIT   = 5'b01111; // cke low during reset
  localparam sdram_cmd_t CMD_NOP    = 5'b10111;
  localparam sdram_cmd_t CMD_PRE    = 5'b10010;
  localparam sdram_cmd_t CMD_REF    = 5'b10001;
  localparam sdram_cmd_t CMD_LMR    = 5'b10000;
  localparam sdram_cmd_t CMD_ACT    = 5'b10011;
  localparam sdram_cmd_t CMD_RD     = 5'b10101;
  localparam sdram_cmd_t CMD_WR     = 5'b10100;
  localparam sdram_cmd_t CMD_BST    = 5'b10110;

endpackage

/* sdram_init_seq.sv */
module sdram_init_seq import sdram_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output sdram_op_e init_op,
  output logic      init_done
);

  typedef enum logic [2:0] {
    s_power, s_pre, s_trp, s_ref, s_trc, s_mrs, s_tmrd, s_done
  } init_state_e;

  init_state_e      state;
  logic [PWR_W-1:0] cnt;     // power-up wait, then reused for the gaps
  logic [3:0]       ref_cnt; // refreshes issued so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= s_power;
      cnt     <= '0;
      ref_cnt <= '0;
    end else begin
      case (state)
        s_power: begin
          if (cnt == PWR_W'(T_POWERUP - 1)) state <= s_pre;
          else cnt <= cnt + 1'b1;
        end
        s_pre: begin
          state <= s_trp;
          cnt   <= PWR_W'(1); // each cmd state seeds the gap count at 1
        end
        s_trp: begin
          if (cnt == PWR_W'(T_RP - 1)) state <= s_ref;
          else cnt <= cnt + 1'b1;
        end
        s_ref: begin
          state   <= s_trc;
          cnt     <= PWR_W'(1);
          ref_cnt <= ref_cnt + 1'b1;
        end
        s_trc: begin
          if (cnt == PWR_W'(T_RC - 1)) begin
            // another refresh or on to the mode load
            state <= (ref_cnt == 4'(INIT_REFRESHES)) ? s_mrs : s_ref;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        s_mrs: begin
          state <= s_tmrd;
          cnt   <= PWR_W'(1);
        end
        s_tmrd: begin
          if (cnt == PWR_W'(T_MRD - 1)) state <= s_done;
          else cnt <= cnt + 1'b1;
        end
        default: state <= s_done; // s_done holds forever
      endcase
    end
  end

  always_comb begin
    case (state)
      s_pre:   init_op = op_precharge_all;
      s_ref:   init_op = op_refresh;
      s_mrs:   init_op = op_load_mode;
      default: init_op = op_nop; // waits are nops
    endcase
  end

  assign init_done = (state == s_done);

  // mode load must not come before the full refresh train
  a_mode_after_refresh: assert property (@(posedge clk) disable iff (!rst_n)
    (init_op == op_load_mode) |-> (ref_cnt == 4'(INIT_REFRESHES)));

endmodule

/* sdram_access_fsm.sv */
module sdram_access_fsm import sdram_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  sdram_op_e init_op,
  input  logic      init_done,
  input  logic      wr_req,
  input  logic      rd_req,
  input  host_req_t req,
  output sdram_op_e op,
  output host_req_t cur_req,
  output logic      wr_ack,
  output logic      rd_capture
);

  typedef enum logic [3:0] {
    s_idle, s_act, s_trcd, s_wr_cmd, s_wr_data,
    s_rd_cmd, s_rd_data, s_twr, s_pre, s_trp
  } state_e;

  state_e           state;
  logic [DLY_W-1:0] cnt;       // single delay / beat counter
  logic             is_wr;     // granted op was a write
  logic [DLY_W-1:0] burst_len; // latched burst, widened
  logic [DLY_W-1:0] rd_end;    // last capture beat count

  assign burst_len = DLY_W'(cur_req.burst);
  assign rd_end    = burst_len + DLY_W'(CAS_LAT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      cnt   <= '0;
      is_wr <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (init_done && (wr_req || rd_req)) begin
            state <= s_act;
            is_wr <= wr_req; // write wins a tie
          end
        end
        s_act: begin
          state <= s_trcd;
          cnt   <= DLY_W'(1);
        end
        s_trcd: begin
          if (cnt == DLY_W'(T_RCD - 1)) state <= is_wr ? s_wr_cmd : s_rd_cmd;
          else cnt <= cnt + 1'b1;
        end
        s_wr_cmd: begin
          state <= s_wr_data;
          cnt   <= DLY_W'(1); // word 0 already taken
        end
        s_wr_data: begin
          if (cnt == burst_len) begin // burst stop goes out this cycle
            state <= s_twr;
            cnt   <= DLY_W'(1);
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        s_rd_cmd: begin
          state <= s_rd_data;
          cnt   <= DLY_W'(1); // cycles since the read op
        end
        s_rd_data: begin
          if (cnt == rd_end) state <= s_pre;
          else cnt <= cnt + 1'b1;
        end
        s_twr: begin
          if (cnt == DLY_W'(T_WR - 1)) state <= s_pre;
          else cnt <= cnt + 1'b1;
        end
        s_pre: begin
          state <= s_trp;
          cnt   <= DLY_W'(1);
        end
        s_trp: begin
          if (cnt == DLY_W'(T_RP - 1)) state <= s_idle;
          else cnt <= cnt + 1'b1;
        end
        default: state <= s_idle;
      endcase
    end
  end

  // request fields held in idle, frozen once granted
  always_ff @(posedge clk) begin
    if (state == s_idle) cur_req <= req;
  end

  always_comb begin
    op = op_nop;
    if (!init_done) begin
      op = init_op; // init sequencer owns the pins
    end else begin
      case (state)
        s_act:     op = op_activate;
        s_wr_cmd:  op = op_write;
        s_rd_cmd:  op = op_read;
        s_wr_data: if (cnt == burst_len) op = op_burst_stop; // after last word
        s_rd_data: if (cnt == burst_len) op = op_burst_stop; // burst after read
        s_pre:     op = op_precharge_bank;
        default:   op = op_nop;
      endcase
    end
  end

  // first beat lines up with the write op
  assign wr_ack = (state == s_wr_cmd) || ((state == s_wr_data) && (cnt < burst_len));
  // data is on dq from CAS_LAT after the read cmd hits the bus
  assign rd_capture = (state == s_rd_data) && (cnt > DLY_W'(CAS_LAT));

  a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_ack && rd_capture));

  // nothing acknowledged while init still runs
  a_no_ack_before_init: assert property (@(posedge clk) disable iff (!rst_n)
    !init_done |-> !(wr_ack || rd_capture));

endmodule

/* sdram_cmd_gen.sv */
module sdram_cmd_gen import sdram_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  sdram_op_e  op,
  input  host_req_t  cur_req,
  output sdram_bus_t bus
);

  sdram_bus_t nxt; // pins for the op this cycle

  always_comb begin
    nxt.cmd  = CMD_NOP;
    nxt.ba   = 2'b11; // idle pattern
    nxt.addr = 12'hfff;
    case (op)
      op_precharge_all: nxt.cmd = CMD_PRE; // A10 high, all banks
      op_refresh:       nxt.cmd = CMD_REF;
      op_burst_stop:    nxt.cmd = CMD_BST;
      op_load_mode: begin
        nxt.cmd  = CMD_LMR;
        nxt.ba   = 2'b00;
        nxt.addr = MODE_WORD;
      end
      op_activate: begin
        nxt.cmd  = CMD_ACT;
        nxt.ba   = cur_req.bank;
        nxt.addr = cur_req.row; // opens the row
      end
      op_read: begin
        nxt.cmd  = CMD_RD;
        nxt.ba   = cur_req.bank;
        nxt.addr = {4'b0000, cur_req.col}; // A10 low, no auto-precharge
      end
      op_write: begin
        nxt.cmd  = CMD_WR;
        nxt.ba   = cur_req.bank;
        nxt.addr = {4'b0000, cur_req.col};
      end
      op_precharge_bank: begin
        nxt.cmd  = CMD_PRE;
        nxt.ba   = cur_req.bank;
        nxt.addr = 12'h000; // single bank close
      end
      default: nxt.cmd = CMD_NOP;
    endcase
  end

  // one register stage to the pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.cmd  <= CMD_INIT; // cke low until sequencing starts
      bus.ba   <= 2'b11;
      bus.addr <= 12'hfff;
    end else begin
      bus <= nxt;
    end
  end

endmodule

/* sdram_dq_path.sv */
module sdram_dq_path import sdram_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_ack,
  input  sdram_word_t din,
  input  logic        rd_capture,
  input  sdram_word_t dq_in,
  output sdram_word_t dq_out,
  output logic        dq_oe,
  output sdram_word_t dout,
  output logic        rd_ack
);

  // write data out, read data in
  always_ff @(posedge clk) begin
    if (wr_ack) dq_out <= din;       // lands with the write cmd / next beat
    if (rd_capture) dout <= dq_in;   // sampled at the pins
  end

  // qualifiers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dq_oe  <= 1'b0;
      rd_ack <= 1'b0;
    end else begin
      dq_oe  <= wr_ack;
      rd_ack <= rd_capture; // valid alongside dout
    end
  end

  // never drive dq while the device is driving it
  a_no_bus_fight: assert property (@(posedge clk) disable iff (!rst_n)
    !(dq_oe && rd_capture));

endmodule

/* sdram_ctrl_top.sv */
module sdram_ctrl_top import sdram_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_req,
  input  logic        rd_req,
  input  host_req_t   req,
  input  sdram_word_t din,
  output logic        wr_ack,
  output logic        rd_ack,
  output sdram_word_t dout,
  output logic        init_done,
  output sdram_bus_t  bus,
  output sdram_word_t dq_out,
  output logic        dq_oe,
  input  sdram_word_t dq_in
);

  sdram_op_e init_op;    // from the power-up sequencer
  sdram_op_e op;         // to the command register
  host_req_t cur_req;    // latched request
  logic      rd_capture; // sample strobe for dq_in

  sdram_init_seq u_init (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_op   (init_op),
    .init_done (init_done)
  );

  sdram_access_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .init_op    (init_op),
    .init_done  (init_done),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .req        (req),
    .op         (op),
    .cur_req    (cur_req),
    .wr_ack     (wr_ack),
    .rd_capture (rd_capture)
  );

  sdram_cmd_gen u_cmd (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (op),
    .cur_req (cur_req),
    .bus     (bus)
  );

  sdram_dq_path u_dq (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_ack     (wr_ack),
    .din        (din),
    .rd_capture (rd_capture),
    .dq_in      (dq_in),
    .dq_out     (dq_out),
    .dq_oe      (dq_oe),
    .dout       (dout),
    .rd_ack     (rd_ack)
  );

endmodule

/* tb_sdram_model.sv */
module tb_sdram_model import sdram_pkg::*; (
  input  logic        clk,
  input  sdram_bus_t  bus,
  input  sdram_word_t dq,     // resolved data bus
  input  logic        dq_oe,
  output sdram_word_t dq_drv, // read data from the device
  output int          gap_errs
);
  timeunit 1ns;
  timeprecision 100ps;

  sdram_word_t mem [logic [21:0]]; // sparse array keyed by {ba, row, col}
  logic [11:0] open_row [4];
  longint      cyc;
  longint      t_act, t_pre, t_ref, t_lmr, t_wdat;
  longint      rd_start, rd_last;
  logic        writing, reading;
  logic [1:0]  wba, rba;
  logic [7:0]  wcol, rcol;    // wrap at 256

  function automatic sdram_word_t fill_word(input logic [21:0] k);
    return k[15:0] ^ {10'b0, k[21:16]}; // unwritten cells
  endfunction

  function automatic sdram_word_t mem_get(input logic [21:0] k);
    if (mem.exists(k)) return mem[k];
    return fill_word(k);
  endfunction

  task automatic check_gap(input string what, input longint since, input int unsigned need);
    if (cyc - since < longint'(need)) begin
      gap_errs++;
      $display("timing gap after %s is %0d cycles, needs %0d", what, cyc - since, need);
    end
  endtask

  initial begin
    gap_errs = 0;
    cyc      = 0;
    t_act    = -1000;
    t_pre    = -1000;
    t_ref    = -1000;
    t_lmr    = -1000;
    t_wdat   = -1000;
    writing  = 1'b0;
    reading  = 1'b0;
    dq_drv   = '0;
  end

  always @(posedge clk) begin
    cyc++;
    if (bus.cmd.cke && !bus.cmd.cs_n && bus.cmd != CMD_NOP) begin
      check_gap("activate", t_act, T_RCD);
      check_gap("precharge", t_pre, T_RP);
      check_gap("refresh", t_ref, T_RC);
      check_gap("mode load", t_lmr, T_MRD);
      if (bus.cmd == CMD_PRE) check_gap("last write word", t_wdat, T_WR);
      case (bus.cmd)
        CMD_ACT: begin
          open_row[bus.ba] = bus.addr;
          t_act = cyc;
        end
        CMD_WR: begin
          writing = 1'b1;
          wba     = bus.ba;
          wcol    = bus.addr[7:0];
        end
        CMD_RD: begin
          reading  = 1'b1;
          rba      = bus.ba;
          rcol     = bus.addr[7:0];
          rd_start = cyc + CAS_LAT - 1; // data valid CAS_LAT edges on
          rd_last  = 64'h7fff_ffff_ffff;
        end
        CMD_BST: begin
          writing = 1'b0;
          if (reading) rd_last = cyc + CAS_LAT - 2; // words already in flight
        end
        CMD_PRE: t_pre = cyc;
        CMD_REF: t_ref = cyc;
        CMD_LMR: t_lmr = cyc;
        default: ;
      endcase
    end
    if (writing && dq_oe) begin
      mem[{wba, open_row[wba], wcol}] = dq;
      wcol++;
      t_wdat = cyc;
    end
    if (reading && cyc >= rd_start) begin
      dq_drv <= mem_get({rba, open_row[rba], rcol});
      rcol++;
      if (cyc == rd_last) reading = 1'b0;
    end
  end

endmodule

/* tb_sdram_ctrl.sv */
module tb_sdram_ctrl import sdram_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_PAIRS = 20;              // random write/read pairs
  localparam int N_XFERS = 2 * N_PAIRS + 4; // plus directed ones

  logic        clk, rst_n, wr_req, rd_req, wr_ack, rd_ack, init_done, dq_oe;
  host_req_t   req;
  sdram_word_t din, dout, dq_out, dq_in, mem_dq;
  sdram_bus_t  bus;
  int          gap_errs;
  sdram_word_t ref_mem [logic [21:0]]; // reference copy of the array

  assign dq_in = dq_oe ? dq_out : mem_dq; // bus resolution

  sdram_ctrl_top dut (.*);

  tb_sdram_model u_mem (
    .clk(clk), .bus(bus), .dq(dq_in), .dq_oe(dq_oe), .dq_drv(mem_dq), .gap_errs(gap_errs)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog sized from power-up plus per-transfer budget
  initial begin
    repeat (T_POWERUP + 600 * N_XFERS) @(posedge clk);
    fail_stop("timeout, run did not finish in the cycle budget");
  end

  // a gap violation seen by the model ends the run at once
  always @(gap_errs) begin
    if (gap_errs != 0) fail_stop("the SDRAM model saw a command gap shorter than allowed");
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input sdram_word_t got, input sdram_word_t exp);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bus(input string name, input sdram_bus_t got, input sdram_bus_t exp);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) fail_stop($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic sdram_bus_t mk_bus(input sdram_cmd_t c, input logic [1:0] ba,
                                        input logic [11:0] a);
    mk_bus = '{cmd: c, ba: ba, addr: a};
  endfunction

  function automatic sdram_word_t ref_get(input host_req_t r, input int k);
    logic [21:0] key;
    key = {r.bank, r.row, r.col + 8'(k)}; // column wraps at 256
    if (ref_mem.exists(key)) return ref_mem[key];
    return key[15:0] ^ {10'b0, key[21:16]}; // same fill as the model
  endfunction

  function automatic logic [BURST_W-1:0] rand_burst();
    return BURST_W'(($urandom % 256) + 1);
  endfunction

  function automatic host_req_t rand_req();
    host_req_t r;
    r.bank  = 2'($urandom);
    r.row   = 12'($urandom);
    r.col   = 8'($urandom);
    r.burst = rand_burst();
    return r;
  endfunction

  // watches the power-up commands while a write waits for init_done
  task automatic check_init(input host_req_t r);
    sdram_bus_t exp_seq [INIT_REFRESHES + 2];
    int         idx;
    exp_seq[0] = mk_bus(CMD_PRE, 2'b11, 12'hfff);
    for (int i = 1; i <= INIT_REFRESHES; i++) exp_seq[i] = mk_bus(CMD_REF, 2'b11, 12'hfff);
    exp_seq[INIT_REFRESHES + 1] = mk_bus(CMD_LMR, 2'b00, MODE_WORD);
    idx    = 0;
    req    = r;
    wr_req = 1'b1; // held across init
    while (!init_done) begin
      @(negedge clk);
      if (wr_ack || rd_ack) fail_stop("request acknowledged before init_done");
      if (bus.cmd != CMD_NOP && bus.cmd != CMD_INIT) begin
        if (idx >= int'(INIT_REFRESHES) + 2) fail_stop("extra command on the bus during init");
        check_bus("bus", bus, exp_seq[idx]);
        idx++;
      end
    end
    check_count("init commands", idx, int'(INIT_REFRESHES) + 2);
  endtask

  // one write, one read, or both raised together
  task automatic run_transfer(input host_req_t r, input bit do_wr, input bit do_rd);
    sdram_word_t wdata [$];
    int          wk, rk, idle;
    for (int i = 0; i < int'(r.burst); i++) wdata.push_back(sdram_word_t'($urandom));
    if (do_wr) begin
      foreach (wdata[i]) ref_mem[{r.bank, r.row, r.col + 8'(i)}] = wdata[i];
    end
    @(negedge clk);
    req    = r;
    wr_req = do_wr;
    rd_req = do_rd;
    din    = wdata[0];
    wk     = 0;
    rk     = 0;
    idle   = 0;
    while (idle < 6) begin // a few extra cycles catch stray acks
      @(negedge clk);
      if (wr_ack) begin
        if (wk < int'(r.burst)) din = wdata[wk]; // taken at the next rising edge
        wk++;
        wr_req = 1'b0;
      end else if (wk > 0 && wk < int'(r.burst)) begin
        fail_stop("wr_ack dropped in the middle of a write burst");
      end
      if (rd_ack) begin
        if (do_wr && wk < int'(r.burst)) fail_stop("rd_ack came before the write finished");
        if (rk < int'(r.burst)) check_word("dout", dout, ref_get(r, rk));
        rk++;
        rd_req = 1'b0;
      end else if (rk > 0 && rk < int'(r.burst)) begin
        fail_stop("rd_ack dropped in the middle of a read burst");
      end
      if ((!do_wr || wk >= int'(r.burst)) && (!do_rd || rk >= int'(r.burst))) idle++;
    end
    check_count("wr_ack cycles", wk, do_wr ? int'(r.burst) : 0);
    check_count("rd_ack cycles", rk, do_rd ? int'(r.burst) : 0);
  endtask

  initial begin
    host_req_t r;
    void'($urandom(84824));
    rst_n  = 1'b0;
    wr_req = 1'b0;
    rd_req = 1'b0;
    req    = '0;
    din    = '0;
    repeat (5) @(negedge clk);
    // reset values
    check_flag("init_done", init_done, 1'b0);
    check_flag("wr_ack", wr_ack, 1'b0);
    check_flag("rd_ack", rd_ack, 1'b0);
    check_flag("dq_oe", dq_oe, 1'b0);
    check_bus("bus", bus, mk_bus(CMD_INIT, 2'b11, 12'hfff));
    rst_n = 1'b1;

    r = rand_req();
    check_init(r);
    run_transfer(r, 1'b1, 1'b0); // the write pending since init
    r.burst = rand_burst();
    run_transfer(r, 1'b0, 1'b1);

    for (int i = 0; i < N_PAIRS; i++) begin
      r = rand_req();
      if (i == 0) begin
        r.col   = 8'hf8; // full page across the wrap
        r.burst = 9'd256;
      end
      run_transfer(r, 1'b1, 1'b0);
      r.burst = rand_burst();
      run_transfer(r, 1'b0, 1'b1);
    end

    r = rand_req();
    run_transfer(r, 1'b1, 1'b1); // write must win the tie

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* filelist.f */
sdram_pkg.sv
sdram_init_seq.sv
sdram_access_fsm.sv
sdram_cmd_gen.sv
sdram_dq_path.sv
sdram_ctrl_top.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_sdram_ctrl
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -Wno-fatal
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "Result: FAILED" $(LOG)
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
